// File: design/dac_ctrl_pkg.sv
package dac_ctrl_pkg;

  // Two-bit command type in the top bits of each command word
  typedef enum logic [1:0] {
    OP_NOOP    = 2'b00, // Delay or trigger wait
    OP_DAC_WR  = 2'b01, // Four pair words follow
    OP_SET_CAL = 2'b10, // Signed per-channel offset
    OP_CANCEL  = 2'b11  // Ends a pending wait with no LDAC
  } opcode_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_DELAY,
    S_TRIG_WAIT,
    S_DAC_WR,
    S_HALT      // Sticky, only reset leaves
  } seq_state_e;

  // Command word layout
  localparam int CMD_W      = 32;
  localparam int DAC_W      = 16;
  localparam int DELAY_W    = 26; // Delay count in bits [25:0]
  localparam int OPC_MSB    = 31;
  localparam int TRIG_BIT   = 29;
  localparam int CONT_BIT   = 28;
  localparam int LDAC_BIT   = 27;
  localparam int CAL_CH_LSB = 16; // Channel field of a set-calibration word

  // Channels and pairs
  localparam int N_CH       = 8;
  localparam int N_PAIRS    = 4;
  localparam int CH_W       = 3;
  localparam int PAIR_IDX_W = $clog2(N_PAIRS);

  // SPI framing
  localparam int FRAME_W            = 24;
  localparam int PAIR_FRAME_W       = 2 * FRAME_W;
  localparam logic [3:0] SPI_WR_CMD = 4'b0001; // Register write, applied on LDAC
  localparam int BIT_W              = $clog2(FRAME_W);

  // 830 ns between chip-select edges at 50 MHz leaves 18 clocks high
  localparam int CS_GAP_CYCLES = 18;
  localparam int GAP_W         = $clog2(CS_GAP_CYCLES + 1);

  // Value ranges
  localparam int CAL_ABS_MAX             = 4096;
  localparam int OFFSET_ZERO             = 32767; // Offset code of zero volts
  localparam logic [15:0] DAC_FORBIDDEN  = 16'hFFFF;

endpackage

// File: design/dac_ctrl_ifs.sv
`timescale 1ns/1ps

// Four-phase request from the sequencer to the pair loader
interface pair_req_if;
  logic                                 req;
  logic [dac_ctrl_pkg::CMD_W-1:0]       pair_word; // Odd channel high, even channel low
  logic [dac_ctrl_pkg::PAIR_IDX_W-1:0]  pair_idx;
  logic                                 val_oob;   // Comes back with ack when rejected
  logic                                 ack;

  modport seq    (output req, pair_word, pair_idx, input ack, val_oob);
  modport loader (input req, pair_word, pair_idx, output ack, val_oob);
endinterface

// Single-cycle calibration write into the table
interface cal_wr_if;
  logic                           wr;
  logic [dac_ctrl_pkg::CH_W-1:0]  ch;
  logic [dac_ctrl_pkg::DAC_W-1:0] value;
  logic                           oob; // Sticky, from the table

  modport seq (output wr, ch, value, input oob);
  modport tbl (input wr, ch, value, output oob);
endinterface

// File: design/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer (
  input  logic                           clk,
  input  logic                           resetn,
  input  logic [dac_ctrl_pkg::CMD_W-1:0] cmd_word,
  input  logic                           cmd_buf_empty,
  input  logic                           trigger,
  input  logic                           ldac_shared,
  output logic                           cmd_rd_en,
  output logic                           waiting_for_trig,
  output logic                           ldac,
  output logic                           cmd_buf_underflow,
  output logic                           unexp_trig,
  output logic                           halt,
  pair_req_if.seq                        pair,
  cal_wr_if.seq                          cal
);

  dac_ctrl_pkg::seq_state_e              state;
  dac_ctrl_pkg::seq_state_e              next_state;
  dac_ctrl_pkg::opcode_e                 opc;
  logic                                  do_ldac;     // Pulse LDAC when the command ends
  logic                                  wait_trig;
  logic                                  expect_next; // Continue bit
  logic [dac_ctrl_pkg::DELAY_W-1:0]      delay_timer;
  logic [dac_ctrl_pkg::PAIR_IDX_W-1:0]   pair_cnt;
  logic                                  pairs_done;
  logic                                  cmd_done;
  logic                                  cancel_wait;
  logic                                  accept;
  logic                                  pair_due;
  logic                                  pair_pop;
  logic                                  err_trig;
  logic                                  err_underflow;
  logic                                  err;

  assign opc = dac_ctrl_pkg::opcode_e'(cmd_word[dac_ctrl_pkg::OPC_MSB -: 2]);

  // A wait finishes on timer expiry or on the trigger it waits for
  assign cmd_done = (state == dac_ctrl_pkg::S_DELAY && delay_timer == '0)
                 || (state == dac_ctrl_pkg::S_TRIG_WAIT && trigger);
  assign cancel_wait = (state == dac_ctrl_pkg::S_DELAY || state == dac_ctrl_pkg::S_TRIG_WAIT)
                    && !cmd_buf_empty && opc == dac_ctrl_pkg::OP_CANCEL;
  assign accept = (state == dac_ctrl_pkg::S_IDLE || cmd_done) && !cmd_buf_empty && !cancel_wait;

  // Next pair word is due once the previous handshake has fully closed
  assign pair_due = state == dac_ctrl_pkg::S_DAC_WR && !pair.req && !pair.ack && !pairs_done;
  assign pair_pop = pair_due && !cmd_buf_empty;

  assign err_trig = (trigger && state != dac_ctrl_pkg::S_TRIG_WAIT)
                 || (ldac_shared && state == dac_ctrl_pkg::S_DAC_WR); // Shared LDAC mid-write
  assign err_underflow = cmd_buf_empty && (pair_due || (cmd_done && expect_next));
  assign err = !halt && (err_trig || err_underflow || cal.oob || pair.val_oob);

  assign cmd_rd_en = !halt && !err && (accept || cancel_wait || pair_pop);
  assign halt = state == dac_ctrl_pkg::S_HALT;
  assign waiting_for_trig = state == dac_ctrl_pkg::S_TRIG_WAIT;

  // Calibration words go straight to the table
  assign cal.wr = accept && !err && opc == dac_ctrl_pkg::OP_SET_CAL;
  assign cal.ch = cmd_word[dac_ctrl_pkg::CAL_CH_LSB +: dac_ctrl_pkg::CH_W];
  assign cal.value = cmd_word[dac_ctrl_pkg::DAC_W-1:0];

  always_comb begin
    case (opc)
      dac_ctrl_pkg::OP_NOOP:
        next_state = cmd_word[dac_ctrl_pkg::TRIG_BIT] ? dac_ctrl_pkg::S_TRIG_WAIT
                                                      : dac_ctrl_pkg::S_DELAY;
      dac_ctrl_pkg::OP_DAC_WR: next_state = dac_ctrl_pkg::S_DAC_WR;
      default:                 next_state = dac_ctrl_pkg::S_IDLE; // Done in one cycle
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= dac_ctrl_pkg::S_IDLE;
    end else if (err) begin
      state <= dac_ctrl_pkg::S_HALT;
    end else if (cancel_wait) begin
      state <= dac_ctrl_pkg::S_IDLE;
    end else if (accept) begin
      state <= next_state;
    end else if (cmd_done) begin
      state <= dac_ctrl_pkg::S_IDLE; // Buffer empty, no continue expected
    end else if (state == dac_ctrl_pkg::S_DAC_WR && pairs_done && !pair.ack) begin
      state <= wait_trig ? dac_ctrl_pkg::S_TRIG_WAIT : dac_ctrl_pkg::S_DELAY;
    end
  end

  // Flag bits only mean something for no-op and DAC write
  always_ff @(posedge clk) begin
    if (!resetn) begin
      do_ldac     <= 1'b0;
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
    end else if (accept) begin
      if (opc == dac_ctrl_pkg::OP_NOOP || opc == dac_ctrl_pkg::OP_DAC_WR) begin
        do_ldac     <= cmd_word[dac_ctrl_pkg::LDAC_BIT];
        wait_trig   <= cmd_word[dac_ctrl_pkg::TRIG_BIT];
        expect_next <= cmd_word[dac_ctrl_pkg::CONT_BIT];
      end else begin
        do_ldac     <= 1'b0;
        wait_trig   <= 1'b0;
        expect_next <= 1'b0;
      end
    end
  end

  // Delay runs from acceptance, so a DAC write overlaps its own delay
  always_ff @(posedge clk) begin
    if (!resetn) begin
      delay_timer <= '0;
    end else if (accept && !cmd_word[dac_ctrl_pkg::TRIG_BIT]
                 && (opc == dac_ctrl_pkg::OP_NOOP || opc == dac_ctrl_pkg::OP_DAC_WR)) begin
      delay_timer <= cmd_word[dac_ctrl_pkg::DELAY_W-1:0];
    end else if (delay_timer != '0) begin
      delay_timer <= delay_timer - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      pair.req   <= 1'b0;
      pair_cnt   <= '0;
      pairs_done <= 1'b0;
    end else if (accept && opc == dac_ctrl_pkg::OP_DAC_WR) begin
      pair_cnt   <= '0;
      pairs_done <= 1'b0;
    end else if (pair_pop && !err) begin
      pair.req <= 1'b1;
    end else if (pair.req && pair.ack) begin
      pair.req   <= 1'b0;
      pair_cnt   <= pair_cnt + 1'b1;
      pairs_done <= &pair_cnt; // Last of the four pairs
    end
  end

  always_ff @(posedge clk) begin
    if (pair_pop) pair.pair_word <= cmd_word; // Held while req is up
  end
  assign pair.pair_idx = pair_cnt;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ldac              <= 1'b0;
      unexp_trig        <= 1'b0;
      cmd_buf_underflow <= 1'b0;
    end else begin
      ldac <= cmd_done && do_ldac && !cancel_wait && !err;
      if (!halt && err_trig) unexp_trig <= 1'b1;
      if (!halt && err_underflow) cmd_buf_underflow <= 1'b1;
    end
  end

  // Two commands ending back to back still give separate pulses
  a_ldac_single: assert property (@(posedge clk) disable iff (!resetn) ldac |=> !ldac);
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!resetn)
    cmd_buf_empty |-> !cmd_rd_en);

endmodule

// File: design/cal_table.sv
`timescale 1ns/1ps

module cal_table (
  input  logic                                clk,
  input  logic                                resetn,
  input  logic [dac_ctrl_pkg::PAIR_IDX_W-1:0] pair_idx,
  cal_wr_if.tbl                               cal,
  output logic signed [dac_ctrl_pkg::DAC_W-1:0] cal_even,
  output logic signed [dac_ctrl_pkg::DAC_W-1:0] cal_odd,
  output logic                                cal_oob
);

  logic signed [dac_ctrl_pkg::DAC_W-1:0] cal_val [dac_ctrl_pkg::N_CH];
  logic                                  in_bounds;

  // Offsets beyond +/- CAL_ABS_MAX are rejected and flagged
  assign in_bounds = $signed(cal.value) <= dac_ctrl_pkg::CAL_ABS_MAX
                  && $signed(cal.value) >= -dac_ctrl_pkg::CAL_ABS_MAX;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < dac_ctrl_pkg::N_CH; i++) begin
        cal_val[i] <= '0; // No offset after reset
      end
      cal_oob <= 1'b0;
    end else if (cal.wr) begin
      if (in_bounds) cal_val[cal.ch] <= cal.value;
      else cal_oob <= 1'b1; // Table keeps its old value
    end
  end

  assign cal.oob = cal_oob;

  // Channels 2i and 2i+1 of the addressed pair
  assign cal_even = cal_val[{pair_idx, 1'b0}];
  assign cal_odd  = cal_val[{pair_idx, 1'b1}];

endmodule

// File: design/dac_pair_loader.sv
`timescale 1ns/1ps

module dac_pair_loader (
  input  logic                                  clk,
  input  logic                                  resetn,
  input  logic signed [dac_ctrl_pkg::DAC_W-1:0] cal_even,
  input  logic signed [dac_ctrl_pkg::DAC_W-1:0] cal_odd,
  input  logic                                  frame_ack,
  pair_req_if.loader                            pair,
  output logic [dac_ctrl_pkg::PAIR_IDX_W-1:0]   pair_idx,
  output logic                                  frame_req,
  output logic [dac_ctrl_pkg::PAIR_FRAME_W-1:0] frames,
  output logic                                  dac_val_oob
);

  typedef enum logic [2:0] {L_IDLE, L_ADD, L_SEND, L_DRAIN, L_DONE} load_state_e;

  load_state_e                           lstate;
  logic signed [dac_ctrl_pkg::DAC_W-1:0] conv_even;
  logic signed [dac_ctrl_pkg::DAC_W-1:0] conv_odd;
  logic signed [dac_ctrl_pkg::DAC_W:0]   sum_even; // One guard bit for the range check
  logic signed [dac_ctrl_pkg::DAC_W:0]   sum_odd;
  logic                                  forbidden;
  logic                                  range_bad;

  // Register write for one channel, back in offset form
  function automatic logic [dac_ctrl_pkg::FRAME_W-1:0] wr_frame(
    input logic [dac_ctrl_pkg::CH_W-1:0]   ch,
    input logic signed [dac_ctrl_pkg::DAC_W:0] val
  );
    return {dac_ctrl_pkg::SPI_WR_CMD, 1'b0, ch,
            dac_ctrl_pkg::DAC_W'(val) + dac_ctrl_pkg::DAC_W'(dac_ctrl_pkg::OFFSET_ZERO)};
  endfunction

  assign pair_idx = pair.pair_idx; // Cal table lookup follows the request
  assign forbidden = pair.pair_word[dac_ctrl_pkg::DAC_W-1:0] == dac_ctrl_pkg::DAC_FORBIDDEN
                  || pair.pair_word[dac_ctrl_pkg::CMD_W-1:dac_ctrl_pkg::DAC_W]
                     == dac_ctrl_pkg::DAC_FORBIDDEN;
  assign sum_even = conv_even + cal_even;
  assign sum_odd  = conv_odd + cal_odd;
  assign range_bad = sum_even > dac_ctrl_pkg::OFFSET_ZERO || sum_even < -dac_ctrl_pkg::OFFSET_ZERO
                  || sum_odd > dac_ctrl_pkg::OFFSET_ZERO || sum_odd < -dac_ctrl_pkg::OFFSET_ZERO;
  assign pair.val_oob = dac_val_oob;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      lstate      <= L_IDLE;
      frame_req   <= 1'b0;
      pair.ack    <= 1'b0;
      dac_val_oob <= 1'b0;
    end else begin
      case (lstate)
        L_IDLE: if (pair.req) begin
          if (forbidden) begin
            dac_val_oob <= 1'b1; // Reject at once, no SPI traffic
            pair.ack    <= 1'b1;
            lstate      <= L_DONE;
          end else begin
            lstate <= L_ADD;
          end
        end
        L_ADD: if (range_bad) begin
          dac_val_oob <= 1'b1;
          pair.ack    <= 1'b1;
          lstate      <= L_DONE;
        end else begin
          frame_req <= 1'b1; // Frames are loaded on this same edge
          lstate    <= L_SEND;
        end
        L_SEND: if (frame_ack) begin
          frame_req <= 1'b0;
          lstate    <= L_DRAIN;
        end
        L_DRAIN: if (!frame_ack) begin
          pair.ack <= 1'b1; // Both frames are out
          lstate   <= L_DONE;
        end
        L_DONE: if (!pair.req) begin
          pair.ack <= 1'b0;
          lstate   <= L_IDLE;
        end
        default: lstate <= L_IDLE;
      endcase
    end
  end

  // Offset to signed is a plain 16-bit subtract, 0 maps to -32767
  always_ff @(posedge clk) begin
    if (lstate == L_IDLE) begin
      conv_even <= pair.pair_word[dac_ctrl_pkg::DAC_W-1:0]
                 - dac_ctrl_pkg::DAC_W'(dac_ctrl_pkg::OFFSET_ZERO);
      conv_odd  <= pair.pair_word[dac_ctrl_pkg::CMD_W-1:dac_ctrl_pkg::DAC_W]
                 - dac_ctrl_pkg::DAC_W'(dac_ctrl_pkg::OFFSET_ZERO);
    end
    if (lstate == L_ADD) begin
      frames <= {wr_frame({pair.pair_idx, 1'b0}, sum_even),  // Even channel goes first
                 wr_frame({pair.pair_idx, 1'b1}, sum_odd)};
    end
  end

  a_no_send_oob: assert property (@(posedge clk) disable iff (!resetn)
    frame_req |-> !dac_val_oob);

endmodule

// File: design/spi_frame_tx.sv
`timescale 1ns/1ps

module spi_frame_tx (
  input  logic                                  clk,
  input  logic                                  resetn,
  input  logic                                  halt,
  input  logic                                  frame_req,
  input  logic [dac_ctrl_pkg::PAIR_FRAME_W-1:0] frames,
  output logic                                  frame_ack,
  output logic                                  n_cs,
  output logic                                  mosi
);

  logic [dac_ctrl_pkg::PAIR_FRAME_W-1:0] shift_q;
  logic [dac_ctrl_pkg::GAP_W-1:0]        gap_cnt; // Chip select high time left
  logic [dac_ctrl_pkg::BIT_W-1:0]        bit_cnt; // Bits left in the frame
  logic                                  second;  // Sending the odd channel
  logic                                  start;

  assign start = frame_req && !frame_ack && n_cs && gap_cnt == '0;
  assign mosi = shift_q[dac_ctrl_pkg::PAIR_FRAME_W-1]; // MSB first

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      n_cs      <= 1'b1;
      frame_ack <= 1'b0;
      gap_cnt   <= '0;
      bit_cnt   <= '0;
      second    <= 1'b0;
    end else if (start) begin
      gap_cnt <= dac_ctrl_pkg::GAP_W'(dac_ctrl_pkg::CS_GAP_CYCLES);
      second  <= 1'b0;
    end else if (gap_cnt != '0) begin
      gap_cnt <= gap_cnt - 1'b1;
      if (gap_cnt == dac_ctrl_pkg::GAP_W'(1)) begin
        n_cs    <= 1'b0; // Gap over, frame starts
        bit_cnt <= dac_ctrl_pkg::BIT_W'(dac_ctrl_pkg::FRAME_W - 1);
      end
    end else if (!n_cs) begin
      if (bit_cnt != '0) begin
        bit_cnt <= bit_cnt - 1'b1;
      end else begin
        n_cs   <= 1'b1; // Each frame under its own chip select
        second <= 1'b1;
        if (second) frame_ack <= 1'b1;
        else gap_cnt <= dac_ctrl_pkg::GAP_W'(dac_ctrl_pkg::CS_GAP_CYCLES);
      end
    end else if (!frame_req) begin
      frame_ack <= 1'b0;
    end
  end

  // One shift per clock while selected, 24 per frame
  always_ff @(posedge clk) begin
    if (start) shift_q <= frames;
    else if (!n_cs) shift_q <= {shift_q[dac_ctrl_pkg::PAIR_FRAME_W-2:0], 1'b0};
  end

endmodule

// File: design/dac_ctrl_top.sv
`timescale 1ns/1ps

module dac_ctrl_top (
  input  logic                           clk,
  input  logic                           resetn,
  input  logic [dac_ctrl_pkg::CMD_W-1:0] cmd_word,
  input  logic                           cmd_buf_empty,
  output logic                           cmd_rd_en,
  input  logic                           trigger,
  input  logic                           ldac_shared,
  output logic                           waiting_for_trig,
  output logic                           cmd_buf_underflow,
  output logic                           unexp_trig,
  output logic                           cal_oob,
  output logic                           dac_val_oob,
  output logic                           n_cs,
  output logic                           mosi,
  output logic                           ldac
);

  logic                                  halt;
  logic [dac_ctrl_pkg::PAIR_IDX_W-1:0]   pair_idx;
  logic signed [dac_ctrl_pkg::DAC_W-1:0] cal_even;
  logic signed [dac_ctrl_pkg::DAC_W-1:0] cal_odd;
  logic                                  frame_req;
  logic                                  frame_ack;
  logic [dac_ctrl_pkg::PAIR_FRAME_W-1:0] frames;

  pair_req_if pair_bus ();
  cal_wr_if   cal_bus ();

  cmd_sequencer u_seq (
    .clk, .resetn, .cmd_word, .cmd_buf_empty, .trigger, .ldac_shared,
    .cmd_rd_en, .waiting_for_trig, .ldac, .cmd_buf_underflow, .unexp_trig, .halt,
    .pair (pair_bus.seq),
    .cal  (cal_bus.seq)
  );

  cal_table u_cal (
    .clk, .resetn, .pair_idx,
    .cal (cal_bus.tbl),
    .cal_even, .cal_odd, .cal_oob
  );

  dac_pair_loader u_loader (
    .clk, .resetn, .cal_even, .cal_odd, .frame_ack,
    .pair (pair_bus.loader),
    .pair_idx, .frame_req, .frames, .dac_val_oob
  );

  // Halt drops chip select mid-frame
  spi_frame_tx u_spi (
    .clk, .resetn, .halt, .frame_req, .frames,
    .frame_ack, .n_cs, .mosi
  );

endmodule

// File: verification/dac_ctrl_tb.sv
`timescale 1ns/1ps

module dac_ctrl_tb;

  localparam int CLK_PERIOD = 40;
  localparam logic [31:0] SEED = 32'hc2a2eac8;
  localparam int CANCEL_DELAY = 1000;
  localparam int HOLD_CYCLES = 100; // Quiet time after each error case
  // A pair is two chip-select gaps and two frames plus handshake overhead
  localparam int PAIR_CYCLES = 2 * (dac_ctrl_pkg::CS_GAP_CYCLES + dac_ctrl_pkg::FRAME_W) + 10;
  localparam int WRITE_CYCLES = dac_ctrl_pkg::N_PAIRS * PAIR_CYCLES + 40;
  localparam int TEST_CYCLES = 2 * WRITE_CYCLES + CANCEL_DELAY + 6 * HOLD_CYCLES + 400;
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES; // Twice the expected run
  localparam int W_FRAMES = 0; // Conditions for wait_for
  localparam int W_LDAC = 1;
  localparam int W_FLAG = 2;
  localparam int W_TRIG = 3;

  logic        clk;
  logic        resetn;
  logic [31:0] cmd_word;
  logic        cmd_buf_empty;
  logic        cmd_rd_en;
  logic        trigger;
  logic        ldac_shared;
  logic        waiting_for_trig;
  logic        cmd_buf_underflow;
  logic        unexp_trig;
  logic        cal_oob;
  logic        dac_val_oob;
  logic        n_cs;
  logic        mosi;
  logic        ldac;

  logic [31:0] cmd_q[$];   // Show-ahead command buffer
  logic [31:0] stage_q[$]; // Words that enter the buffer together
  logic        popped;     // Read seen at the last rising edge
  int          pop_count;
  int          ldac_count; // Cycles with ldac high
  int          cs_low_count;
  int          frame_count;
  logic [23:0] frame_log [0:63];
  logic [23:0] shift_in;
  int          bit_count;
  int          error_count;
  int          check_count;
  int          pop_base;
  int          ldac_base;
  int          frame_base;
  int          cs_base;
  logic [15:0] dac_code [8];  // Offset-form values of the next write
  logic [15:0] cal_model [8]; // Expected calibration per channel

  dac_ctrl_top DUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Buffer pops on cmd_rd_en at the rising edge, new head shows on the falling edge
  always @(posedge clk) begin
    popped <= resetn && cmd_rd_en === 1'b1;
    if (resetn && cmd_rd_en === 1'b1) pop_count <= pop_count + 1;
  end

  always @(negedge clk) begin
    if (popped) begin
      if (cmd_q.size() == 0) report_failure("Command buffer was read while empty");
      else void'(cmd_q.pop_front());
    end
    cmd_buf_empty = cmd_q.size() == 0;
    cmd_word = cmd_buf_empty ? '0 : cmd_q[0];
  end

  // Frame monitor, MSB first, one bit per falling edge under chip select
  always @(negedge clk) begin
    if (ldac === 1'b1) ldac_count <= ldac_count + 1;
    if (n_cs === 1'b0) begin
      cs_low_count <= cs_low_count + 1;
      shift_in <= {shift_in[22:0], mosi};
      if (bit_count == dac_ctrl_pkg::FRAME_W - 1) begin
        frame_log[frame_count % 64] <= {shift_in[22:0], mosi};
        frame_count <= frame_count + 1;
        check_value(shift_in[22:19], 4'b0001, "frame command code"); // Register write
        bit_count <= 0;
      end else begin
        bit_count <= bit_count + 1;
      end
    end else begin
      bit_count <= 0; // Partial frame dropped
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH at %0t ns: %s: got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  task automatic check_flags(input logic [3:0] expected);
    check_value({cmd_buf_underflow, unexp_trig, cal_oob, dac_val_oob}, expected,
                "flags underflow, unexp_trig, cal_oob, dac_val_oob");
  endtask

  // Two reset cycles, buffer emptied, calibration back to zero
  task automatic apply_reset();
    @(negedge clk);
    resetn  = 1'b0;
    trigger = 1'b0;
    @(posedge clk);
    cmd_q.delete();
    stage_q.delete();
    repeat (2) @(negedge clk);
    resetn = 1'b1;
    foreach (cal_model[i]) cal_model[i] = '0;
  endtask

  task automatic mark_counts();
    pop_base   = pop_count;
    ldac_base  = ldac_count;
    frame_base = frame_count;
    cs_base    = cs_low_count;
  endtask

  function automatic logic [31:0] make_cmd(input dac_ctrl_pkg::opcode_e opc, input logic trig,
                                            input logic cont, input logic ld, input int delay);
    logic [31:0] w;
    w = '0;
    w[dac_ctrl_pkg::OPC_MSB -: 2] = opc;
    w[dac_ctrl_pkg::TRIG_BIT] = trig;
    w[dac_ctrl_pkg::CONT_BIT] = cont;
    w[dac_ctrl_pkg::LDAC_BIT] = ld;
    w[dac_ctrl_pkg::DELAY_W-1:0] = delay;
    return w;
  endfunction

  function automatic logic [15:0] random_code(input int lo, input int hi);
    return 16'(lo + $urandom % (hi - lo + 1));
  endfunction

  // Set-calibration word; the model only takes in-bounds offsets
  task automatic stage_cal(input int ch, input int value);
    logic [31:0] w;
    w = make_cmd(dac_ctrl_pkg::OP_SET_CAL, 1'b0, 1'b0, 1'b0, 0);
    w[dac_ctrl_pkg::CAL_CH_LSB +: 3] = 3'(ch);
    w[15:0] = 16'(value);
    stage_q.push_back(w);
    if (value >= -4096 && value <= 4096) cal_model[ch] = 16'(value);
  endtask

  task automatic stage_write(input logic ld, input int delay);
    stage_q.push_back(make_cmd(dac_ctrl_pkg::OP_DAC_WR, 1'b0, 1'b0, ld, delay));
    for (int p = 0; p < dac_ctrl_pkg::N_PAIRS; p++) begin
      stage_q.push_back({dac_code[2*p+1], dac_code[2*p]}); // Odd channel in the high half
    end
  endtask

  // All staged words land in one cycle so pair words are never late
  task automatic send_staged();
    @(posedge clk);
    foreach (stage_q[i]) cmd_q.push_back(stage_q[i]);
    stage_q.delete();
    @(negedge clk);
  endtask

  function automatic bit condition_met(input int kind, input int target);
    case (kind)
      W_FRAMES: return frame_count - frame_base >= target;
      W_LDAC:   return ldac_count - ldac_base >= target;
      W_FLAG:   return (cmd_buf_underflow | unexp_trig | cal_oob | dac_val_oob) === 1'b1;
      default:  return waiting_for_trig === 1'b1;
    endcase
  endfunction

  task automatic wait_for(input int kind, input int target, input int limit, input string what);
    int n;
    n = 0;
    while (!condition_met(kind, target) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!condition_met(kind, target)) report_failure({"Timed out waiting for ", what});
  endtask

  // Frame value is the offset code plus the channel's calibration
  task automatic check_frames();
    logic [15:0] code;
    for (int ch = 0; ch < dac_ctrl_pkg::N_CH; ch++) begin
      code = dac_code[ch] + cal_model[ch];
      check_value(frame_log[(frame_base + ch) % 64], {4'b0001, 1'b0, 3'(ch), code},
                  $sformatf("frame for channel %0d", ch));
    end
  endtask

  task automatic finish_write(input int words);
    wait_for(W_FRAMES, 8, WRITE_CYCLES, "eight frames");
    check_value(ldac_count - ldac_base, 0, "ldac pulses before the last frame");
    wait_for(W_LDAC, 1, 50, "ldac pulse");
    repeat (20) @(negedge clk);
    check_frames();
    check_value(frame_count - frame_base, 8, "frames per write");
    check_value(ldac_count - ldac_base, 1, "ldac pulses");
    check_value(pop_count - pop_base, words, "words read");
    check_flags(4'b0000);
  endtask

  task automatic uncalibrated_write();
    apply_reset();
    mark_counts();
    foreach (dac_code[i]) dac_code[i] = random_code(0, 16'hFFFE);
    stage_write(1'b1, 10);
    send_staged();
    finish_write(5);
  endtask

  task automatic calibrated_write();
    apply_reset();
    mark_counts();
    stage_cal(0, 100);
    stage_cal(3, -250);
    stage_cal(5, 4096); // Both bounds are legal
    stage_cal(6, -4096);
    foreach (dac_code[i]) dac_code[i] = random_code(4096, 61438); // Sum stays in range
    stage_write(1'b1, 0);
    send_staged();
    finish_write(9);
  endtask

  task automatic triggered_noop();
    apply_reset();
    mark_counts();
    stage_q.push_back(make_cmd(dac_ctrl_pkg::OP_NOOP, 1'b1, 1'b0, 1'b1, 0));
    send_staged();
    wait_for(W_TRIG, 0, 20, "waiting_for_trig");
    repeat (30) @(negedge clk);
    check_value(waiting_for_trig, 1'b1, "waiting_for_trig before trigger");
    check_value(ldac_count - ldac_base, 0, "ldac pulses before trigger");
    trigger = 1'b1;
    @(negedge clk);
    trigger = 1'b0;
    wait_for(W_LDAC, 1, 20, "ldac after trigger");
    repeat (5) @(negedge clk);
    check_value(ldac_count - ldac_base, 1, "ldac pulses after trigger");
    check_value(waiting_for_trig, 1'b0, "waiting_for_trig after trigger");
    check_flags(4'b0000);
    trigger = 1'b1; // Nothing waits for this one
    @(negedge clk);
    trigger = 1'b0;
    wait_for(W_FLAG, 0, 20, "unexp_trig");
    repeat (5) @(negedge clk);
    check_flags(4'b0100);
    check_value(ldac_count - ldac_base, 1, "ldac pulses after stray trigger");
  endtask

  task automatic cancelled_delay();
    apply_reset();
    mark_counts();
    stage_q.push_back(make_cmd(dac_ctrl_pkg::OP_NOOP, 1'b0, 1'b0, 1'b1, CANCEL_DELAY));
    send_staged();
    repeat (20) @(negedge clk);
    stage_q.push_back(make_cmd(dac_ctrl_pkg::OP_CANCEL, 1'b0, 1'b0, 1'b0, 0));
    send_staged();
    repeat (CANCEL_DELAY + 50) @(negedge clk); // Past the original delay
    check_value(ldac_count - ldac_base, 0, "ldac pulses after cancel");
    check_value(pop_count - pop_base, 2, "words read up to cancel");
    stage_q.push_back(make_cmd(dac_ctrl_pkg::OP_NOOP, 1'b0, 1'b0, 1'b1, 5));
    send_staged();
    wait_for(W_LDAC, 1, 30, "ldac of command after cancel");
    check_value(pop_count - pop_base, 3, "words read after cancel");
    check_flags(4'b0000);
  endtask

  task automatic expect_halt(input logic [3:0] flags, input int words, input string what);
    wait_for(W_FLAG, 0, 100, what);
    repeat (HOLD_CYCLES) @(negedge clk);
    check_flags(flags);
    check_value(pop_count - pop_base, words, "words read before halt");
    check_value(ldac_count - ldac_base, 0, "ldac pulses after error");
    check_value(cs_low_count - cs_base, 0, "chip select low cycles after error");
    check_value(n_cs, 1'b1, "n_cs in halt");
  endtask

  task automatic error_halts();
    apply_reset(); // Calibration out of bounds, later write ignored
    mark_counts();
    foreach (dac_code[i]) dac_code[i] = random_code(0, 16'hFFFE);
    stage_cal(2, 5000);
    stage_write(1'b1, 0);
    send_staged();
    expect_halt(4'b0010, 1, "cal_oob");
    apply_reset(); // Forbidden code in the first pair
    mark_counts();
    dac_code[0] = 16'hFFFF;
    stage_write(1'b1, 0);
    send_staged();
    expect_halt(4'b0001, 2, "dac_val_oob on 16'hFFFF");
    apply_reset(); // Offset pushes channel 0 past the top of the range
    mark_counts();
    dac_code[0] = 16'd65500;
    stage_cal(0, 100);
    stage_write(1'b1, 0);
    send_staged();
    expect_halt(4'b0001, 3, "dac_val_oob on range");
    apply_reset(); // Continue bit with nothing behind it
    mark_counts();
    stage_q.push_back(make_cmd(dac_ctrl_pkg::OP_NOOP, 1'b0, 1'b1, 1'b1, 5));
    send_staged();
    expect_halt(4'b1000, 1, "cmd_buf_underflow");
  endtask

  initial begin
    clk           = 1'b0;
    resetn        = 1'b0;
    cmd_word      = '0;
    cmd_buf_empty = 1'b1;
    trigger       = 1'b0;
    ldac_shared   = 1'b0;
    popped        = 1'b0;
    void'($urandom(SEED));
    uncalibrated_write();
    calibrated_write();
    triggered_noop();
    cancelled_delay();
    error_halts();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Backstop if a wait never ends
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: project.f
design/dac_ctrl_pkg.sv
design/dac_ctrl_ifs.sv
design/cmd_sequencer.sv
design/cal_table.sv
design/dac_pair_loader.sv
design/spi_frame_tx.sv
design/dac_ctrl_top.sv
verification/dac_ctrl_tb.sv

// File: Bender.yml
package:
  name: dac_ctrl

sources:
  - design/dac_ctrl_pkg.sv
  - design/dac_ctrl_ifs.sv
  - design/cmd_sequencer.sv
  - design/cal_table.sv
  - design/dac_pair_loader.sv
  - design/spi_frame_tx.sv
  - design/dac_ctrl_top.sv
  - target: simulation
    files:
      - verification/dac_ctrl_tb.sv
